/* src/mipsPkg.sv */
package mipsPkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      regIdx_t;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct field of OP_SPECIAL
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI  // opB shifted into the upper half
    } aluOp_t;

    typedef struct packed {
        word_t   pc;
        word_t   opA;
        word_t   opB;        // register or extended immediate
        word_t   storeData;  // rt value for sw
        regIdx_t dest;
        aluOp_t  aluOp;
        logic    regWrite;
        logic    isLoad;
        logic    isStore;
        logic    valid;
    } decEx_t;

    typedef struct packed {
        word_t   pc;
        word_t   result;     // also the data address
        word_t   storeData;
        regIdx_t dest;
        logic    regWrite;
        logic    isLoad;
        logic    isStore;
        logic    valid;
    } exMem_t;

    typedef struct packed {
        word_t   pc;
        word_t   result;
        regIdx_t dest;
        logic    regWrite;
        logic    isLoad;
        logic    valid;
    } memWb_t;

endpackage

/* src/bypassIf.sv */
`timescale 1ns/1ps

// pending register write of a later stage, seen by decode
interface bypassIf;

    logic             writeEn;  // valid instruction that writes a register
    mipsPkg::regIdx_t dest;
    mipsPkg::word_t   value;
    logic             isLoad;   // load data not back yet

    modport stage (output writeEn, dest, value, isLoad);

    modport decode (input writeEn, dest, value, isLoad);

endinterface

/* src/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit #(
    parameter mipsPkg::word_t RESET_PC = 32'hbfc00000
) (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           stall_i,
    input  logic           redirect_i,
    input  mipsPkg::word_t target_i,
    output mipsPkg::word_t pc_o
);

    // delay slot is already on pc_o when decode redirects
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_o <= RESET_PC;
        end else if (!stall_i) begin
            pc_o <= redirect_i ? target_i : pc_o + 32'd4;
        end
    end

    // branch and jump targets from decode must keep the PC aligned
    pcAligned: assert property (@(posedge clk_i) disable iff (rst_i)
        pc_o[1:0] == 2'b00)
        else $error("fetch PC %h not word aligned", pc_o);

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic             clk_i,
    input  logic             rst_i,
    input  mipsPkg::regIdx_t rdAddrA_i,
    input  mipsPkg::regIdx_t rdAddrB_i,
    output mipsPkg::word_t   rdDataA_o,
    output mipsPkg::word_t   rdDataB_o,
    input  logic             we_i,
    input  mipsPkg::regIdx_t wrAddr_i,
    input  mipsPkg::word_t   wrData_i
);

    mipsPkg::word_t regs [1:31];  // no storage for r0

    always_ff @(posedge clk_i) begin
        if (we_i && wrAddr_i != '0) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

    // same-cycle write is seen by the read
    assign rdDataA_o = (rdAddrA_i == '0) ? '0 :
                       (we_i && wrAddr_i == rdAddrA_i) ? wrData_i : regs[rdAddrA_i];
    assign rdDataB_o = (rdAddrB_i == '0) ? '0 :
                       (we_i && wrAddr_i == rdAddrB_i) ? wrData_i : regs[rdAddrB_i];

    r0StaysZero: assert property (@(posedge clk_i) disable iff (rst_i)
        we_i && wrAddr_i == '0 |=> rdAddrA_i != '0 || rdDataA_o == '0)
        else $error("r0 read back nonzero after a write to it");

endmodule

/* src/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
    input  logic             clk_i,
    input  logic             rst_i,
    input  mipsPkg::word_t   pc_i,
    input  mipsPkg::word_t   instr_i,
    input  logic             wbWe_i,
    input  mipsPkg::regIdx_t wbDest_i,
    input  mipsPkg::word_t   wbData_i,
    bypassIf.decode          bypassE,
    bypassIf.decode          bypassM,
    bypassIf.decode          bypassW,
    output logic             stall_o,
    output logic             redirect_o,
    output mipsPkg::word_t   target_o,
    output mipsPkg::decEx_t  decEx_o
);

    mipsPkg::word_t   pcQ;
    mipsPkg::word_t   instrQ;
    logic             validQ;
    logic [5:0]       opcode;
    mipsPkg::regIdx_t aIdx;
    mipsPkg::regIdx_t bIdx;
    mipsPkg::word_t   rfA;
    mipsPkg::word_t   rfB;
    mipsPkg::word_t   srcA;
    mipsPkg::word_t   srcB;
    mipsPkg::word_t   immSext;
    mipsPkg::word_t   pcPlus4;
    logic             isJ;
    logic             taken;
    logic             hazE;
    logic             hazM;
    logic             hazW;
    mipsPkg::decEx_t  decExD;

    function automatic logic hit(input logic we, input mipsPkg::regIdx_t dest,
                                 input mipsPkg::regIdx_t src);
        return we && dest == src && src != '0;
    endfunction

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            validQ <= 1'b0;
        end else if (!stall_o) begin
            validQ <= 1'b1;
            pcQ    <= pc_i;
            instrQ <= instr_i;
        end
    end

    assign opcode  = instrQ[31:26];
    assign isJ     = opcode == mipsPkg::OP_J;
    assign immSext = {{16{instrQ[15]}}, instrQ[15:0]};
    assign pcPlus4 = pcQ + 32'd4;

    // zero index for fields that are not sources, so they never stall
    assign aIdx = (isJ || opcode == mipsPkg::OP_LUI) ? '0 : instrQ[25:21];
    assign bIdx = (opcode == mipsPkg::OP_SPECIAL || opcode == mipsPkg::OP_SW ||
                   opcode == mipsPkg::OP_BEQ || opcode == mipsPkg::OP_BNE) ? instrQ[20:16] : '0;

    regFile rf (
        .clk_i(clk_i), .rst_i(rst_i),
        .rdAddrA_i(instrQ[25:21]), .rdAddrB_i(instrQ[20:16]),
        .rdDataA_o(rfA), .rdDataB_o(rfB),
        .we_i(wbWe_i), .wrAddr_i(wbDest_i), .wrData_i(wbData_i)
    );

    // youngest producer wins
    assign srcA = hit(bypassE.writeEn, bypassE.dest, aIdx) ? bypassE.value :
                  hit(bypassM.writeEn, bypassM.dest, aIdx) ? bypassM.value :
                  hit(bypassW.writeEn, bypassW.dest, aIdx) ? bypassW.value : rfA;
    assign srcB = hit(bypassE.writeEn, bypassE.dest, bIdx) ? bypassE.value :
                  hit(bypassM.writeEn, bypassM.dest, bIdx) ? bypassM.value :
                  hit(bypassW.writeEn, bypassW.dest, bIdx) ? bypassW.value : rfB;

    assign hazE = bypassE.isLoad && (hit(bypassE.writeEn, bypassE.dest, aIdx) ||
                                     hit(bypassE.writeEn, bypassE.dest, bIdx));
    assign hazM = bypassM.isLoad && (hit(bypassM.writeEn, bypassM.dest, aIdx) ||
                                     hit(bypassM.writeEn, bypassM.dest, bIdx));
    assign hazW = bypassW.isLoad && (hit(bypassW.writeEn, bypassW.dest, aIdx) ||
                                     hit(bypassW.writeEn, bypassW.dest, bIdx));
    assign stall_o = validQ && (hazE || hazM || hazW);

    // fetch ignores the redirect while stalled
    assign taken = (opcode == mipsPkg::OP_BEQ && srcA == srcB) ||
                   (opcode == mipsPkg::OP_BNE && srcA != srcB);
    assign redirect_o = validQ && (isJ || taken);
    assign target_o   = isJ ? {pcPlus4[31:28], instrQ[25:0], 2'b00} :
                              pcPlus4 + {immSext[29:0], 2'b00};

    always_comb begin
        decExD           = '0;
        decExD.pc        = pcQ;
        decExD.opA       = srcA;
        decExD.opB       = immSext;
        decExD.storeData = srcB;
        decExD.dest      = instrQ[20:16];
        decExD.aluOp     = mipsPkg::ALU_ADD;
        decExD.valid     = validQ && !stall_o;  // bubble while stalled
        case (opcode)
            mipsPkg::OP_SPECIAL: begin
                decExD.opB      = srcB;
                decExD.dest     = instrQ[15:11];
                decExD.regWrite = 1'b1;
                case (instrQ[5:0])
                    mipsPkg::FN_ADDU: decExD.aluOp = mipsPkg::ALU_ADD;
                    mipsPkg::FN_SUBU: decExD.aluOp = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND:  decExD.aluOp = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:   decExD.aluOp = mipsPkg::ALU_OR;
                    mipsPkg::FN_SLT:  decExD.aluOp = mipsPkg::ALU_SLT;
                    default:          decExD.regWrite = 1'b0;  // nop
                endcase
            end
            mipsPkg::OP_ADDIU: decExD.regWrite = 1'b1;
            mipsPkg::OP_ORI, mipsPkg::OP_LUI: begin
                decExD.opB      = {16'h0, instrQ[15:0]};
                decExD.aluOp    = (opcode == mipsPkg::OP_ORI) ? mipsPkg::ALU_OR : mipsPkg::ALU_LUI;
                decExD.regWrite = 1'b1;
            end
            mipsPkg::OP_LW: begin
                decExD.regWrite = 1'b1;
                decExD.isLoad   = 1'b1;
            end
            mipsPkg::OP_SW: decExD.isStore = 1'b1;
            default: ;  // branches and jumps end here
        endcase
    end

    always_ff @(posedge clk_i) begin
        decEx_o <= decExD;
        if (rst_i) begin
            decEx_o.valid <= 1'b0;
        end
    end

    // a load holds decode through execute and memory only
    stallBounded: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_o ##1 stall_o |=> !stall_o)
        else $error("decode stalled with the load already in writeback");

endmodule

/* src/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  logic            clk_i,
    input  logic            rst_i,
    input  mipsPkg::decEx_t decEx_i,
    bypassIf.stage          bypassE,
    bypassIf.stage          bypassM,
    output mipsPkg::exMem_t exMem_o,
    output logic            memEn_o,
    output logic            memWe_o,
    output mipsPkg::word_t  memAddr_o,
    output mipsPkg::word_t  memWdata_o
);

    mipsPkg::word_t aluRes;

    always_comb begin
        case (decEx_i.aluOp)
            mipsPkg::ALU_SUB: aluRes = decEx_i.opA - decEx_i.opB;
            mipsPkg::ALU_AND: aluRes = decEx_i.opA & decEx_i.opB;
            mipsPkg::ALU_OR:  aluRes = decEx_i.opA | decEx_i.opB;
            mipsPkg::ALU_SLT: aluRes = {{(mipsPkg::XLEN-1){1'b0}},
                                        $signed(decEx_i.opA) < $signed(decEx_i.opB)};
            mipsPkg::ALU_LUI: aluRes = {decEx_i.opB[15:0], 16'h0};
            default:          aluRes = decEx_i.opA + decEx_i.opB;  // also load/store address
        endcase
    end

    // loads only have an address here
    assign bypassE.writeEn = decEx_i.valid && decEx_i.regWrite;
    assign bypassE.dest    = decEx_i.dest;
    assign bypassE.value   = aluRes;
    assign bypassE.isLoad  = decEx_i.isLoad;

    always_ff @(posedge clk_i) begin
        exMem_o <= '{pc: decEx_i.pc, result: aluRes, storeData: decEx_i.storeData,
                     dest: decEx_i.dest, regWrite: decEx_i.regWrite,
                     isLoad: decEx_i.isLoad, isStore: decEx_i.isStore,
                     valid: decEx_i.valid};
        if (rst_i) begin
            exMem_o.valid <= 1'b0;
        end
    end

    assign bypassM.writeEn = exMem_o.valid && exMem_o.regWrite;
    assign bypassM.dest    = exMem_o.dest;
    assign bypassM.value   = exMem_o.result;
    assign bypassM.isLoad  = exMem_o.isLoad;  // data comes back next cycle

    assign memEn_o    = exMem_o.valid && (exMem_o.isLoad || exMem_o.isStore);
    assign memWe_o    = exMem_o.valid && exMem_o.isStore;
    assign memAddr_o  = exMem_o.result;
    assign memWdata_o = exMem_o.storeData;

    // decode never marks a store as a register write
    storeIsMemOp: assert property (@(posedge clk_i) disable iff (rst_i)
        memWe_o |-> memEn_o && !bypassM.writeEn)
        else $error("store at %h without enable or with a register write", memAddr_o);

endmodule

/* src/resultStage.sv */
`timescale 1ns/1ps

module resultStage (
    input  logic             clk_i,
    input  logic             rst_i,
    input  mipsPkg::exMem_t  exMem_i,
    input  mipsPkg::word_t   memRdata_i,
    bypassIf.stage           bypassW,
    output logic             wbWe_o,
    output mipsPkg::regIdx_t wbDest_o,
    output mipsPkg::word_t   wbData_o,
    output logic             wbValid_o,
    output mipsPkg::word_t   wbPc_o,
    output mipsPkg::regIdx_t wbReg_o
);

    mipsPkg::memWb_t memWbQ;

    always_ff @(posedge clk_i) begin
        memWbQ <= '{pc: exMem_i.pc, result: exMem_i.result, dest: exMem_i.dest,
                    regWrite: exMem_i.regWrite, isLoad: exMem_i.isLoad,
                    valid: exMem_i.valid};
        if (rst_i) begin
            memWbQ.valid <= 1'b0;
        end
    end

    assign wbData_o = memWbQ.isLoad ? memRdata_i : memWbQ.result;  // read data lands now
    assign wbWe_o   = memWbQ.valid && memWbQ.regWrite;
    assign wbDest_o = memWbQ.dest;

    assign bypassW.writeEn = wbWe_o;
    assign bypassW.dest    = memWbQ.dest;
    assign bypassW.value   = wbData_o;
    assign bypassW.isLoad  = 1'b0;  // value complete in writeback

    // debug port, r0 writes included
    assign wbValid_o = wbWe_o;
    assign wbPc_o    = memWbQ.pc;
    assign wbReg_o   = memWbQ.dest;

endmodule

/* src/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore #(
    parameter mipsPkg::word_t RESET_PC = 32'hbfc00000
) (
    input  logic             clk_i,
    input  logic             rst_i,
    output mipsPkg::word_t   pc_o,
    input  mipsPkg::word_t   instr_i,
    output logic             memEn_o,
    output logic             memWe_o,
    output mipsPkg::word_t   memAddr_o,
    output mipsPkg::word_t   memWdata_o,
    input  mipsPkg::word_t   memRdata_i,
    output logic             wbValid_o,
    output mipsPkg::word_t   wbPc_o,
    output mipsPkg::regIdx_t wbReg_o,
    output mipsPkg::word_t   wbData_o
);

    logic             stall;
    logic             redirect;
    mipsPkg::word_t   target;
    mipsPkg::decEx_t  decEx;
    mipsPkg::exMem_t  exMem;
    logic             wbWe;
    mipsPkg::regIdx_t wbDest;

    bypassIf bypassE ();
    bypassIf bypassM ();
    bypassIf bypassW ();

    fetchUnit #(.RESET_PC(RESET_PC)) fetch (
        .clk_i(clk_i), .rst_i(rst_i),
        .stall_i(stall), .redirect_i(redirect), .target_i(target),
        .pc_o(pc_o)
    );

    decodeStage decode (
        .clk_i(clk_i), .rst_i(rst_i),
        .pc_i(pc_o), .instr_i(instr_i),
        .wbWe_i(wbWe), .wbDest_i(wbDest), .wbData_i(wbData_o),
        .bypassE(bypassE), .bypassM(bypassM), .bypassW(bypassW),
        .stall_o(stall), .redirect_o(redirect), .target_o(target),
        .decEx_o(decEx)
    );

    executeStage execute (
        .clk_i(clk_i), .rst_i(rst_i),
        .decEx_i(decEx), .bypassE(bypassE), .bypassM(bypassM), .exMem_o(exMem),
        .memEn_o(memEn_o), .memWe_o(memWe_o),
        .memAddr_o(memAddr_o), .memWdata_o(memWdata_o)
    );

    resultStage result (
        .clk_i(clk_i), .rst_i(rst_i),
        .exMem_i(exMem), .memRdata_i(memRdata_i), .bypassW(bypassW),
        .wbWe_o(wbWe), .wbDest_o(wbDest), .wbData_o(wbData_o),
        .wbValid_o(wbValid_o), .wbPc_o(wbPc_o), .wbReg_o(wbReg_o)
    );

endmodule

/* include/tbProgram.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int DMEM_WORDS = 64;  // data memory from byte address 0

// program loaded at RESET_PC, nops past the end
localparam int PROG_LEN = 30;
localparam logic [31:0] PROG [PROG_LEN] = '{
    32'h3c011234,  // lui   r1, 0x1234
    32'h34215678,  // ori   r1, r1, 0x5678
    32'h24020005,  // addiu r2, r0, 5
    32'h00221821,  // addu  r3, r1, r2
    32'h00622023,  // subu  r4, r3, r2
    32'h00812824,  // and   r5, r4, r1
    32'h00a23025,  // or    r6, r5, r2
    32'h0041382a,  // slt   r7, r2, r1
    32'h8c080008,  // lw    r8, 8(r0)
    32'h01024821,  // addu  r9, r8, r2    load in execute
    32'h8c0a000c,  // lw    r10, 12(r0)
    32'h240b0001,  // addiu r11, r0, 1
    32'h014b6021,  // addu  r12, r10, r11 load in memory
    32'hac090010,  // sw    r9, 16(r0)
    32'hac0c0014,  // sw    r12, 20(r0)
    32'h8c0d0010,  // lw    r13, 16(r0)
    32'h24000007,  // addiu r0, r0, 7
    32'h00027021,  // addu  r14, r0, r2
    32'h10420002,  // beq   r2, r2, +2    taken
    32'h240f0003,  // addiu r15, r0, 3    delay slot
    32'h24100009,  // addiu r16, r0, 9    skipped
    32'h14420002,  // bne   r2, r2, +2    not taken
    32'h25f10001,  // addiu r17, r15, 1
    32'h16220002,  // bne   r17, r2, +2   taken
    32'h24120002,  // addiu r18, r0, 2
    32'h24130004,  // addiu r19, r0, 4    skipped
    32'h0bf0001d,  // j     word 29
    32'h0251a021,  // addu  r20, r18, r17 delay slot
    32'h24150001,  // addiu r21, r0, 1    skipped
    32'h028db021   // addu  r22, r20, r13
};

`endif

/* tests/tbMipsCore.sv */
`timescale 1ns/1ps

module tbMipsCore;

    `include "tbProgram.svh"

    localparam logic [31:0] RESET_PC = 32'hbfc00000;
    localparam int PERIOD = 20;
    localparam int RESET_CYCLES = 10;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 8 * PROG_LEN;

    logic clk = 1'b0;
    logic rst;
    logic [31:0] pc, instr, memAddr, memWdata, memRdata, wbPc, wbData;
    logic memEn, memWe, wbValid;
    logic [4:0] wbReg;

    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] refMem [DMEM_WORDS];
    logic [31:0] refRegs [32];
    logic [31:0] rdAddr = '0;
    logic [31:0] expPc [PROG_LEN];
    logic [4:0]  expReg [PROG_LEN];
    logic [31:0] expData [PROG_LEN];
    logic [31:0] expStAddr [PROG_LEN];
    logic [31:0] expStData [PROG_LEN];
    int wbCount = 0, stCount = 0, wbIdx = 0, stIdx = 0, cycleCnt = 0;
    int resetErrs = 0, wbErrs = 0, stErrs = 0, memErrs = 0;

    mipsCore #(.RESET_PC(RESET_PC)) UUT (
        .clk_i(clk), .rst_i(rst), .pc_o(pc), .instr_i(instr),
        .memEn_o(memEn), .memWe_o(memWe), .memAddr_o(memAddr),
        .memWdata_o(memWdata), .memRdata_i(memRdata),
        .wbValid_o(wbValid), .wbPc_o(wbPc), .wbReg_o(wbReg), .wbData_o(wbData)
    );

    initial begin
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int memIdx(input logic [31:0] addr);
        return (addr >> 2) % DMEM_WORDS;
    endfunction

    // nop outside the program
    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_PC) >> 2;
        return (idx < PROG_LEN) ? PROG[idx] : 32'h0;
    endfunction

    task automatic fillMemory();
        logic [31:0] state;
        state = 32'h5a0da67c;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            state = lcgNext(state ^ i);  // mixes in the word address
            dmem[i] = state;
            refMem[i] = state;
        end
    endtask

    // sequential ISA model, one delay slot after every branch and jump
    task automatic runModel();
        logic [31:0] curPc, nextPc, afterPc, ins, rs, rt, imm, res;
        logic [4:0] dest;
        logic wr;
        curPc = RESET_PC;
        nextPc = RESET_PC + 32'd4;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        while (((curPc - RESET_PC) >> 2) < PROG_LEN) begin
            ins = fetchWord(curPc);
            rs = refRegs[ins[25:21]];
            rt = refRegs[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            afterPc = nextPc + 32'd4;
            dest = ins[20:16];
            wr = 1'b1;
            res = '0;
            case (ins[31:26])
                6'h00: begin
                    dest = ins[15:11];
                    case (ins[5:0])
                        6'h21: res = rs + rt;
                        6'h23: res = rs - rt;
                        6'h24: res = rs & rt;
                        6'h25: res = rs | rt;
                        6'h2a: res = {31'b0, $signed(rs) < $signed(rt)};
                        default: wr = 1'b0;
                    endcase
                end
                6'h09: res = rs + imm;  // addiu
                6'h0d: res = rs | {16'h0, ins[15:0]};
                6'h0f: res = {ins[15:0], 16'h0};
                6'h23: res = refMem[memIdx(rs + imm)];
                6'h2b: begin
                    wr = 1'b0;
                    refMem[memIdx(rs + imm)] = rt;
                    expStAddr[stCount] = rs + imm;
                    expStData[stCount] = rt;
                    stCount++;
                end
                6'h04: begin
                    wr = 1'b0;
                    if (rs == rt) afterPc = nextPc + {imm[29:0], 2'b00};
                end
                6'h05: begin
                    wr = 1'b0;
                    if (rs != rt) afterPc = nextPc + {imm[29:0], 2'b00};
                end
                6'h02: begin
                    wr = 1'b0;
                    afterPc = {nextPc[31:28], ins[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr) begin
                expPc[wbCount] = curPc;  // r0 writes still show on the debug port
                expReg[wbCount] = dest;
                expData[wbCount] = res;
                wbCount++;
                if (dest != 5'd0) refRegs[dest] = res;
            end
            curPc = nextPc;
            nextPc = afterPc;
        end
    endtask

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (!rst && wbValid) wbIdx <= wbIdx + 1;
        if (!rst && memWe) stIdx <= stIdx + 1;
        if (memEn && memWe) begin
            dmem[memIdx(memAddr)] <= memWdata;
        end else if (memEn) begin
            rdAddr <= memAddr;
        end
    end

    always @(negedge clk) begin
        instr <= fetchWord(pc);
        memRdata <= dmem[memIdx(rdAddr)];  // read data one cycle after the request
    end

    resetQuiet: assert property (@(posedge clk) cycleCnt inside {[1:RESET_CYCLES]} |->
        pc == RESET_PC && !memEn && !wbValid)
        else begin
            $display("FAIL %0t: after reset pc %h memEn %b wbValid %b", $time,
                     $sampled(pc), $sampled(memEn), $sampled(wbValid));
            resetErrs++;
        end

    wbInOrder: assert property (@(posedge clk) disable iff (rst) wbValid |->
        wbIdx < wbCount && wbPc == expPc[wbIdx] && wbReg == expReg[wbIdx] &&
        wbData == expData[wbIdx])
        else begin
            $display("FAIL %0t: writeback %0d pc %h r%0d = %h, expected pc %h r%0d = %h",
                     $time, $sampled(wbIdx), $sampled(wbPc), $sampled(wbReg),
                     $sampled(wbData), expPc[$sampled(wbIdx)], expReg[$sampled(wbIdx)],
                     expData[$sampled(wbIdx)]);
            wbErrs++;
        end

    storeInOrder: assert property (@(posedge clk) disable iff (rst) memWe |->
        stIdx < stCount && memAddr == expStAddr[stIdx] && memWdata == expStData[stIdx])
        else begin
            $display("FAIL %0t: store %0d at %h data %h, expected %h data %h", $time,
                     $sampled(stIdx), $sampled(memAddr), $sampled(memWdata),
                     expStAddr[$sampled(stIdx)], expStData[$sampled(stIdx)]);
            stErrs++;
        end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("timeout: program not retired within %0d cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int totalErrs;
        rst = 1'b1;
        instr = '0;
        memRdata = '0;
        fillMemory();
        runModel();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        #1;
        $display("test reset: %0d cycles checked, %0d errors", RESET_CYCLES, resetErrs);
        wait (wbIdx == wbCount && stIdx == stCount);
        repeat (8) @(posedge clk);  // drain, catches extra writebacks
        $display("test writeback trace: %0d of %0d, %0d errors", wbIdx, wbCount, wbErrs);
        $display("test stores: %0d of %0d, %0d errors", stIdx, stCount, stErrs);
        for (int i = 0; i < DMEM_WORDS; i++) begin
            finalWord: assert (dmem[i] === refMem[i])
                else begin
                    $display("FAIL %0t: memory word %0d is %h, expected %h", $time, i,
                             dmem[i], refMem[i]);
                    memErrs++;
                end
        end
        $display("test final memory: %0d words, %0d errors", DMEM_WORDS, memErrs);
        totalErrs = resetErrs + wbErrs + stErrs + memErrs;
        $display("4 tests, %0d checks, %0d errors", RESET_CYCLES + wbIdx + stIdx + DMEM_WORDS,
                 totalErrs);
        if (totalErrs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
src/mipsPkg.sv
src/bypassIf.sv
src/fetchUnit.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/resultStage.sv
src/mipsCore.sv
tests/tbMipsCore.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - files:
      - src/mipsPkg.sv
      - src/bypassIf.sv
      - src/fetchUnit.sv
      - src/regFile.sv
      - src/decodeStage.sv
      - src/executeStage.sv
      - src/resultStage.sv
      - src/mipsCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tbMipsCore.sv
